//--- files.f
+incdir+hw
hw/regread_pkg.sv
hw/bypass_match.sv
hw/bypass_capture.sv
hw/bypass_stage.sv
hw/regread_bypass.sv
verif/regread_properties.sv
verif/tb_clock.sv
verif/tb_checker.sv
verif/tb_top.sv

//--- hw/bypass_capture.sv
`timescale 1ns/1ps
`include "regread_settings.svh"

// First bypass stage, sits in the cycle the tag enters
module bypass_capture (
  input  logic                                                       clk,
  input  logic                                                       reset_i,
  input  regread_pkg::phys_tag_t                                     phys_src_i,
  input  regread_pkg::slice_t                                        prf_slice0_i,
  input  regread_pkg::slice_t                                        prf_slice1_i,
  input  regread_pkg::slice_t                                        prf_slice2_i,
  input  regread_pkg::slice_t                                        prf_slice3_i,
  input  logic [`REGREAD_ISSUE_WIDTH-1:0]                            bypass_valid_i,
  input  logic [`REGREAD_ISSUE_WIDTH*`REGREAD_TAG_WIDTH-1:0]         bypass_tag_i,
  input  logic [`REGREAD_ISSUE_WIDTH*$bits(regread_pkg::word_t)-1:0] bypass_data_i,
  output regread_pkg::phys_tag_t                                     tag_o,
  output logic                                                       seen_o,
  output regread_pkg::word_t                                         word_o
);

  logic               hit;         // Some valid lane carries this tag now
  regread_pkg::word_t bypass_word; // Winning lane's word
  regread_pkg::word_t prf_word;    // All four register file inputs side by side

  bypass_match u_match (
    .tag_i          (phys_src_i),
    .bypass_valid_i (bypass_valid_i),
    .bypass_tag_i   (bypass_tag_i),
    .bypass_data_i  (bypass_data_i),
    .hit_o          (hit),
    .word_o         (bypass_word)
  );

  // Only slice 0 belongs to this read in this cycle
  // Slices 1 to 3 are for older reads and get replaced further down the chain
  assign prf_word = {prf_slice3_i, prf_slice2_i, prf_slice1_i, prf_slice0_i};

  always_ff @(posedge clk)
  begin
    if (reset_i)
    begin
      tag_o  <= '0;
      seen_o <= 1'b0; // No history survives reset
      word_o <= '0;
    end
    else
    begin
      tag_o  <= phys_src_i;
      seen_o <= hit;    // Later stages hold the bypass word when this is set
      if (hit)
      begin
        word_o <= bypass_word; // All four slices come from the lane
      end
      else
      begin
        word_o <= prf_word;
      end
    end
  end

endmodule

//--- hw/bypass_match.sv
`timescale 1ns/1ps
`include "regread_settings.svh"

// Tag compare against all issue lanes with a one-hot word select
module bypass_match (
  input  regread_pkg::phys_tag_t                                     tag_i,
  input  logic [`REGREAD_ISSUE_WIDTH-1:0]                            bypass_valid_i,
  input  logic [`REGREAD_ISSUE_WIDTH*`REGREAD_TAG_WIDTH-1:0]         bypass_tag_i,
  input  logic [`REGREAD_ISSUE_WIDTH*$bits(regread_pkg::word_t)-1:0] bypass_data_i,
  output logic                                                       hit_o,
  output regread_pkg::word_t                                         word_o
);

  localparam int TW = `REGREAD_TAG_WIDTH;
  localparam int WW = $bits(regread_pkg::word_t);

  logic [`REGREAD_ISSUE_WIDTH-1:0] lane_match; // One bit per lane, at most one set

  // A lane only counts when its valid bit is up
  always_comb
  begin
    for (int i = 0; i < `REGREAD_ISSUE_WIDTH; i++)
    begin
      lane_match[i] = bypass_valid_i[i] && (bypass_tag_i[i*TW +: TW] == tag_i);
    end
  end

  assign hit_o = |lane_match; // Any lane hit

  // One-hot encoder built as an AND-OR tree
  // Lanes that do not match contribute zero, so the OR leaves the single winner
  always_comb
  begin
    word_o = '0;
    for (int i = 0; i < `REGREAD_ISSUE_WIDTH; i++)
    begin
      word_o = word_o | ({WW{lane_match[i]}} & bypass_data_i[i*WW +: WW]);
    end
  end

endmodule

//--- hw/bypass_stage.sv
`timescale 1ns/1ps
`include "regread_settings.svh"

// Later bypass stage, owns the slice whose index equals STAGE
// The last stage is combinational and produces the result directly
module bypass_stage #(
  parameter int STAGE = 1
) (
  input  logic                                                       clk,
  input  logic                                                       reset_i,
  input  regread_pkg::phys_tag_t                                     tag_i,
  input  logic                                                       seen_i,
  input  regread_pkg::word_t                                         word_i,
  input  regread_pkg::slice_t                                        prf_slice_i,
  input  logic [`REGREAD_ISSUE_WIDTH-1:0]                            bypass_valid_i,
  input  logic [`REGREAD_ISSUE_WIDTH*`REGREAD_TAG_WIDTH-1:0]         bypass_tag_i,
  input  logic [`REGREAD_ISSUE_WIDTH*$bits(regread_pkg::word_t)-1:0] bypass_data_i,
  output regread_pkg::phys_tag_t                                     tag_o,
  output logic                                                       seen_o,
  output regread_pkg::word_t                                         word_o
);

  localparam int SW   = `REGREAD_SLICE_WIDTH;
  localparam int LAST = `REGREAD_SLICE_COUNT - 1; // Index of the final stage

  logic                   hit;         // Match for this stage's tag in this cycle
  regread_pkg::word_t     bypass_word;
  regread_pkg::byte_src_e slice_src [`REGREAD_SLICE_COUNT];
  regread_pkg::word_t     merged_word; // Word after this stage's choice
  logic                   merged_seen; // History including this stage

  bypass_match u_match (
    .tag_i          (tag_i),
    .bypass_valid_i (bypass_valid_i),
    .bypass_tag_i   (bypass_tag_i),
    .bypass_data_i  (bypass_data_i),
    .hit_o          (hit),
    .word_o         (bypass_word)
  );

  // Pick a source for each slice
  // A fresh hit always wins since it is the newest producer of the register
  always_comb
  begin
    for (int k = 0; k < `REGREAD_SLICE_COUNT; k++)
    begin
      if (hit)
      begin
        slice_src[k] = regread_pkg::SRC_BYPASS;
      end
      else if ((k == STAGE) && !seen_i)
      begin
        slice_src[k] = regread_pkg::SRC_PRF; // Owned slice, nothing bypassed so far
      end
      else
      begin
        // An earlier match already placed the lane's slice here
        slice_src[k] = regread_pkg::SRC_HELD;
      end
    end
  end

  always_comb
  begin
    for (int k = 0; k < `REGREAD_SLICE_COUNT; k++)
    begin
      case (slice_src[k])
        regread_pkg::SRC_BYPASS: merged_word[k*SW +: SW] = bypass_word[k*SW +: SW];
        regread_pkg::SRC_PRF:    merged_word[k*SW +: SW] = prf_slice_i;
        default:                 merged_word[k*SW +: SW] = word_i[k*SW +: SW];
      endcase
    end
  end

  assign merged_seen = seen_i | hit; // Sticky across the remaining stages

  generate
    if (STAGE == LAST)
    begin : g_comb
      // Final stage drives the result in the same cycle
      assign tag_o  = tag_i;
      assign seen_o = merged_seen;
      assign word_o = merged_word;
    end
    else
    begin : g_reg
      always_ff @(posedge clk)
      begin
        if (reset_i)
        begin
          tag_o  <= '0;
          seen_o <= 1'b0;
          word_o <= '0;
        end
        else
        begin
          tag_o  <= tag_i;       // Tag follows its data down the chain
          seen_o <= merged_seen;
          word_o <= merged_word;
        end
      end
    end
  endgenerate

endmodule

//--- hw/regread_bypass.sv
`timescale 1ns/1ps
`include "regread_settings.svh"

// Register read bypass, result valid three cycles after the tag enters
module regread_bypass (
  input  logic                                                       clk,
  input  logic                                                       reset_i,
  input  regread_pkg::phys_tag_t                                     phys_src_i,
  input  regread_pkg::slice_t                                        prf_slice0_i,
  input  regread_pkg::slice_t                                        prf_slice1_i,
  input  regread_pkg::slice_t                                        prf_slice2_i,
  input  regread_pkg::slice_t                                        prf_slice3_i,
  input  logic [`REGREAD_ISSUE_WIDTH-1:0]                            bypass_valid_i,
  input  logic [`REGREAD_ISSUE_WIDTH*`REGREAD_TAG_WIDTH-1:0]         bypass_tag_i,
  input  logic [`REGREAD_ISSUE_WIDTH*$bits(regread_pkg::word_t)-1:0] bypass_data_i,
  output regread_pkg::word_t                                         data_o
);

  // Chain between stages, index is the producing stage
  regread_pkg::phys_tag_t tag_s0;
  regread_pkg::phys_tag_t tag_s1;
  regread_pkg::phys_tag_t tag_s2;
  logic                   seen_s0;
  logic                   seen_s1;
  logic                   seen_s2;
  regread_pkg::word_t     word_s0;
  regread_pkg::word_t     word_s1;
  regread_pkg::word_t     word_s2;

  bypass_capture u_capture (
    .clk            (clk),
    .reset_i        (reset_i),
    .phys_src_i     (phys_src_i),
    .prf_slice0_i   (prf_slice0_i),
    .prf_slice1_i   (prf_slice1_i),
    .prf_slice2_i   (prf_slice2_i),
    .prf_slice3_i   (prf_slice3_i),
    .bypass_valid_i (bypass_valid_i),
    .bypass_tag_i   (bypass_tag_i),
    .bypass_data_i  (bypass_data_i),
    .tag_o          (tag_s0),
    .seen_o         (seen_s0),
    .word_o         (word_s0)
  );

  bypass_stage #(.STAGE(1)) u_stage1 (
    .clk            (clk),
    .reset_i        (reset_i),
    .tag_i          (tag_s0),
    .seen_i         (seen_s0),
    .word_i         (word_s0),
    .prf_slice_i    (prf_slice1_i), // Slice 1 of the read one cycle older
    .bypass_valid_i (bypass_valid_i),
    .bypass_tag_i   (bypass_tag_i),
    .bypass_data_i  (bypass_data_i),
    .tag_o          (tag_s1),
    .seen_o         (seen_s1),
    .word_o         (word_s1)
  );

  bypass_stage #(.STAGE(2)) u_stage2 (
    .clk            (clk),
    .reset_i        (reset_i),
    .tag_i          (tag_s1),
    .seen_i         (seen_s1),
    .word_i         (word_s1),
    .prf_slice_i    (prf_slice2_i),
    .bypass_valid_i (bypass_valid_i),
    .bypass_tag_i   (bypass_tag_i),
    .bypass_data_i  (bypass_data_i),
    .tag_o          (tag_s2),
    .seen_o         (seen_s2),
    .word_o         (word_s2)
  );

  // Last stage is combinational, its tag and history go nowhere
  bypass_stage #(.STAGE(3)) u_stage3 (
    .clk            (clk),
    .reset_i        (reset_i),
    .tag_i          (tag_s2),
    .seen_i         (seen_s2),
    .word_i         (word_s2),
    .prf_slice_i    (prf_slice3_i),
    .bypass_valid_i (bypass_valid_i),
    .bypass_tag_i   (bypass_tag_i),
    .bypass_data_i  (bypass_data_i),
    .tag_o          (),
    .seen_o         (),
    .word_o         (data_o)
  );

endmodule

//--- hw/regread_pkg.sv
`include "regread_settings.svh"

package regread_pkg;

  // Physical register number carried down the read pipeline
  typedef logic [`REGREAD_TAG_WIDTH-1:0] phys_tag_t;

  // One register file delivery
  typedef logic [`REGREAD_SLICE_WIDTH-1:0] slice_t;

  // Full operand, slice 0 sits in the low bits
  typedef logic [`REGREAD_SLICE_COUNT*`REGREAD_SLICE_WIDTH-1:0] word_t;

  // Where a stage takes one slice of its word from
  typedef enum logic [1:0] {
    SRC_BYPASS = 2'd0, // Matching lane's word in this cycle
    SRC_HELD   = 2'd1, // Slice already held by the previous stage
    SRC_PRF    = 2'd2  // Slice arriving from the register file now
  } byte_src_e;

endpackage

//--- hw/regread_settings.svh
`ifndef REGREAD_SETTINGS_SVH
`define REGREAD_SETTINGS_SVH

// Number of issue lanes that drive a bypass result every cycle
`define REGREAD_ISSUE_WIDTH 4

// Bits delivered by the register file per cycle
`define REGREAD_SLICE_WIDTH 8

// Slices per operand, which also sets the number of bypass stages
`define REGREAD_SLICE_COUNT 4

// Width of a physical register tag
`define REGREAD_TAG_WIDTH 7

`endif

//--- verif/regread_properties.sv
`timescale 1ns/1ps
`include "regread_settings.svh"

// Assertions on the bypass chain that get bound into regread_bypass
module regread_properties (
  input logic                                               clk,
  input logic                                               reset_i,
  input regread_pkg::phys_tag_t                             phys_src_i,
  input logic [`REGREAD_ISSUE_WIDTH-1:0]                    bypass_valid_i,
  input logic [`REGREAD_ISSUE_WIDTH*`REGREAD_TAG_WIDTH-1:0] bypass_tag_i,
  input regread_pkg::phys_tag_t                             tag_s0_i,
  input regread_pkg::phys_tag_t                             tag_s1_i,
  input regread_pkg::phys_tag_t                             tag_s2_i,
  input logic                                               seen_s0_i,
  input logic                                               seen_s1_i,
  input logic                                               seen_s2_i,
  input regread_pkg::word_t                                 word_s2_i,
  input regread_pkg::word_t                                 data_i
);

  localparam int N  = `REGREAD_ISSUE_WIDTH;
  localparam int TW = `REGREAD_TAG_WIDTH;
  localparam int SW = `REGREAD_SLICE_WIDTH;

  int           fail_count = 0; // Failed assertions so far
  logic [N-1:0] hits_s0; // Lanes matching the tag in the capture stage
  logic [N-1:0] hits_s1;
  logic [N-1:0] hits_s2;
  logic [N-1:0] hits_s3; // Lanes matching the tag in the last stage

  function automatic logic [N-1:0] lane_hits(input regread_pkg::phys_tag_t tag,
                                             input logic [N-1:0] valid,
                                             input logic [N*TW-1:0] tags);
    logic [N-1:0] hits;
    for (int i = 0; i < N; i++)
    begin
      hits[i] = valid[i] && (tags[i*TW +: TW] == tag);
    end
    return hits;
  endfunction

  assign hits_s0 = lane_hits(phys_src_i, bypass_valid_i, bypass_tag_i);
  assign hits_s1 = lane_hits(tag_s0_i, bypass_valid_i, bypass_tag_i);
  assign hits_s2 = lane_hits(tag_s1_i, bypass_valid_i, bypass_tag_i);
  assign hits_s3 = lane_hits(tag_s2_i, bypass_valid_i, bypass_tag_i);

  a_one_lane: assert property (@(posedge clk) disable iff (reset_i)
    $onehot0(hits_s0) && $onehot0(hits_s1) && $onehot0(hits_s2) && $onehot0(hits_s3))
    else
    begin
      fail_count++;
      $error("More than one valid bypass lane matches a stage tag");
    end

  a_seen_cleared: assert property (@(posedge clk)
    reset_i |=> (!seen_s0_i && !seen_s1_i && !seen_s2_i))
    else
    begin
      fail_count++;
      $error("Match history is not clear after reset");
    end

  // Held slice 3 must pass through the last stage untouched
  a_held_slice3: assert property (@(posedge clk) disable iff (reset_i)
    (seen_s2_i && !(|hits_s3)) |-> (data_i[3*SW +: SW] == word_s2_i[3*SW +: SW]))
    else
    begin
      fail_count++;
      $error("Last stage replaced a held slice 3 without a bypass hit");
    end

endmodule

//--- verif/regread_testdata.txt
// Columns: tag slice0 slice1 slice2 slice3, then valid tag word for lanes 0 to 3,
// then check flag and expected data_o for the read that entered three rows earlier
// No lane matches, result built from staggered register file slices
10 00 40 80 C0 0 00 00000000 0 00 00000000 0 00 00000000 0 00 00000000 0 00000000
11 01 41 81 C1 0 00 00000000 0 00 00000000 0 00 00000000 0 00 00000000 0 00000000
12 02 42 82 C2 0 00 00000000 0 00 00000000 0 00 00000000 0 00 00000000 0 00000000
// Lane 0 matches tag 13 in the cycle it enters
13 03 43 83 C3 1 13 B1B2B3B4 0 00 00000000 0 00 00000000 0 00 00000000 1 C3824100
14 04 44 84 C4 0 00 00000000 0 00 00000000 0 00 00000000 0 00 00000000 1 C4834201
15 05 45 85 C5 0 00 00000000 0 00 00000000 0 00 00000000 0 00 00000000 1 C5844302
// Middle stage matches for tags 14 and 15
16 06 46 86 C6 0 00 00000000 1 14 C1C2C3C4 1 15 D1D2D3D4 0 00 00000000 1 B1B2B3B4
17 07 47 87 C7 0 00 00000000 0 00 00000000 0 00 00000000 0 00 00000000 1 C1C2C3C4
18 08 48 88 C8 0 00 00000000 0 00 00000000 0 00 00000000 0 00 00000000 1 D1D2D3D4
// Last stage match for tag 16, first of two matches for tag 19
19 09 49 89 C9 1 16 E1E2E3E4 1 19 11111111 0 00 00000000 0 00 00000000 1 E1E2E3E4
1A 0A 4A 8A CA 0 00 00000000 0 00 00000000 1 1A 33333333 0 00 00000000 1 CA894807
1B 0B 4B 8B CB 0 00 00000000 0 00 00000000 0 00 00000000 1 19 22222222 1 CB8A4908
1C 0C 4C 8C CC 0 00 00000000 1 1B 55555555 0 00 00000000 0 00 00000000 1 22222222
1D 0D 4D 8D CD 1 1A 44444444 0 00 00000000 0 00 00000000 0 00 00000000 1 44444444
// Back to back reads with a mix of bypassed and plain results
1E 0E 4E 8E CE 1 1E 0A0B0C0D 0 00 00000000 0 00 00000000 0 00 00000000 1 55555555
1F 0F 4F 8F CF 0 00 00000000 0 00 00000000 0 00 00000000 0 00 00000000 1 CF8E4D0C
20 10 50 90 D0 0 00 00000000 0 00 00000000 0 00 00000000 0 00 00000000 1 D08F4E0D
21 11 51 91 D1 0 00 00000000 0 00 00000000 1 20 12345678 0 00 00000000 1 0A0B0C0D
22 12 52 92 D2 0 00 00000000 0 00 00000000 0 00 00000000 0 00 00000000 1 D291500F
23 13 53 93 D3 0 00 00000000 0 00 00000000 0 00 00000000 1 21 9ABCDEF0 1 12345678
24 14 54 94 D4 1 24 76543210 0 00 00000000 0 00 00000000 0 00 00000000 1 9ABCDEF0
25 15 55 95 D5 0 00 00000000 0 00 00000000 0 00 00000000 0 00 00000000 1 D5945312
// Lanes with matching tags but valid low are ignored
26 16 56 96 D6 0 00 00000000 1 23 0F1E2D3C 0 26 FFFFFFFF 0 00 00000000 1 0F1E2D3C
27 17 57 97 D7 0 00 00000000 0 00 00000000 0 00 00000000 0 00 00000000 1 76543210
28 18 58 98 D8 0 00 00000000 0 00 00000000 0 00 00000000 0 26 EEEEEEEE 1 D8975615
29 19 59 99 D9 0 28 99999999 1 28 88888888 0 00 00000000 0 00 00000000 1 D9985716
2A 1A 5A 9A DA 0 27 13579BDF 0 00 00000000 0 00 00000000 0 00 00000000 1 DA995817
2B 1B 5B 9B DB 0 00 00000000 0 00 00000000 0 00 00000000 0 00 00000000 1 88888888
2C 1C 5C 9C DC 0 00 00000000 0 00 00000000 0 00 00000000 0 00 00000000 1 DC9B5A19
2D 1D 5D 9D DD 0 00 00000000 0 00 00000000 0 00 00000000 0 00 00000000 1 DD9C5B1A
2E 1E 5E 9E DE 0 00 00000000 0 00 00000000 0 00 00000000 0 00 00000000 1 DE9D5C1B
2F 1F 5F 9F DF 0 00 00000000 0 00 00000000 0 00 00000000 0 00 00000000 1 DF9E5D1C

//--- verif/tb_checker.sv
`timescale 1ns/1ps

// Watches data_o and compares it with the expected word of each flagged cycle
module tb_checker (
  input  logic               clk,
  input  logic               check_en_i,  // The current cycle carries an expected result
  input  regread_pkg::word_t expected_i,
  input  regread_pkg::word_t data_i,      // DUT result that is combinational in the current cycle
  output int                 check_count_o,
  output int                 error_count_o
);

  initial
  begin
    check_count_o = 0;
    error_count_o = 0;
  end

  // Inputs change on the rising edge, so the falling edge sees settled values
  always @(negedge clk)
  begin
    if (check_en_i)
    begin
      check_count_o = check_count_o + 1;
      if (data_i !== expected_i) // Also catches X or Z on the result
      begin
        error_count_o = error_count_o + 1;
        $display("[ERROR] data_o: expected 0x%08h, actual 0x%08h at %0t ns",
                 expected_i, data_i, $time);
      end
    end
  end

  // Closing line with all counts
  task automatic print_summary(input int assert_errors, input int other_errors);
    $display("Summary: %0d checks, %0d data mismatches, %0d assertion failures, %0d other errors",
             check_count_o, error_count_o, assert_errors, other_errors);
  endtask

endmodule

//--- verif/tb_clock.sv
`timescale 1ns/1ps

// Free running clock for the testbench
module tb_clock #(
  parameter int HALF_PERIOD_NS = 20 // 40 ns period
) (
  output logic clk_o
);

  initial
  begin
    clk_o = 1'b0; // First rising edge after half a period
  end

  always #(HALF_PERIOD_NS) clk_o = ~clk_o;

endmodule

//--- verif/tb_top.sv
`timescale 1ns/1ps
`include "regread_settings.svh"

module tb_top;

  localparam int FIELDS      = 19; // Values per row of the stimulus table
  localparam int MAX_ROWS    = 64;
  localparam int DRAIN_LIMIT = 8;  // Cycles allowed for the checker to catch up
  localparam int LANES       = `REGREAD_ISSUE_WIDTH;
  localparam int TW          = `REGREAD_TAG_WIDTH;
  localparam int SW          = `REGREAD_SLICE_WIDTH;
  localparam int WW          = $bits(regread_pkg::word_t);

  logic                   clk;
  logic                   reset_i;
  regread_pkg::phys_tag_t phys_src;
  regread_pkg::slice_t    prf_slice0;
  regread_pkg::slice_t    prf_slice1;
  regread_pkg::slice_t    prf_slice2;
  regread_pkg::slice_t    prf_slice3;
  logic [LANES-1:0]       bypass_valid;
  logic [LANES*TW-1:0]    bypass_tag;
  logic [LANES*WW-1:0]    bypass_data;
  regread_pkg::word_t     data;
  logic                   check_en;
  regread_pkg::word_t     expected_word;
  int                     check_count;
  int                     error_count;
  int                     other_errors;  // Timeouts and table problems
  int                     assert_errors; // Failed assertions in the bound checker
  int                     flagged_rows;
  int                     row;
  int                     addr;
  int                     wait_cycles;
  logic [31:0]            table_mem [0:FIELDS*MAX_ROWS-1];

  tb_clock u_clock (
    .clk_o (clk)
  );

  regread_bypass dut (
    .clk            (clk),
    .reset_i        (reset_i),
    .phys_src_i     (phys_src),
    .prf_slice0_i   (prf_slice0),
    .prf_slice1_i   (prf_slice1),
    .prf_slice2_i   (prf_slice2),
    .prf_slice3_i   (prf_slice3),
    .bypass_valid_i (bypass_valid),
    .bypass_tag_i   (bypass_tag),
    .bypass_data_i  (bypass_data),
    .data_o         (data)
  );

  tb_checker u_checker (
    .clk           (clk),
    .check_en_i    (check_en),
    .expected_i    (expected_word),
    .data_i        (data),
    .check_count_o (check_count),
    .error_count_o (error_count)
  );

  bind regread_bypass regread_properties u_props (
    .clk            (clk),
    .reset_i        (reset_i),
    .phys_src_i     (phys_src_i),
    .bypass_valid_i (bypass_valid_i),
    .bypass_tag_i   (bypass_tag_i),
    .tag_s0_i       (tag_s0),
    .tag_s1_i       (tag_s1),
    .tag_s2_i       (tag_s2),
    .seen_s0_i      (seen_s0),
    .seen_s1_i      (seen_s1),
    .seen_s2_i      (seen_s2),
    .word_s2_i      (word_s2),
    .data_i         (data_o)
  );

  // Quiet bus with no lane valid and no check
  task automatic drive_idle();
    phys_src      <= '0;
    prf_slice0    <= '0;
    prf_slice1    <= '0;
    prf_slice2    <= '0;
    prf_slice3    <= '0;
    bypass_valid  <= '0;
    bypass_tag    <= '0;
    bypass_data   <= '0;
    check_en      <= 1'b0;
    expected_word <= '0;
  endtask

  // Row layout is tag, four slices, then valid, tag and word per lane, then flag and result
  task automatic drive_row(input int idx);
    int base;
    int lane;
    base = idx * FIELDS;
    phys_src   <= table_mem[base][TW-1:0];
    prf_slice0 <= table_mem[base+1][SW-1:0];
    prf_slice1 <= table_mem[base+2][SW-1:0];
    prf_slice2 <= table_mem[base+3][SW-1:0];
    prf_slice3 <= table_mem[base+4][SW-1:0];
    for (lane = 0; lane < LANES; lane++)
    begin
      bypass_valid[lane]          <= table_mem[base+5+3*lane][0];
      bypass_tag[lane*TW +: TW]   <= table_mem[base+6+3*lane][TW-1:0];
      bypass_data[lane*WW +: WW]  <= table_mem[base+7+3*lane];
    end
    check_en      <= table_mem[base+17][0];
    expected_word <= table_mem[base+18];
  endtask

  initial
  begin
    reset_i       = 1'b1;
    other_errors  = 0;
    assert_errors = 0;
    flagged_rows  = 0;
    drive_idle();

    // Fill values all have bit 31 set, which no tag in the table can have
    for (addr = 0; addr < FIELDS*MAX_ROWS; addr++)
    begin
      table_mem[addr] = 32'h8000_0000 | addr;
    end
    $readmemh("verif/regread_testdata.txt", table_mem);

    repeat (16) @(posedge clk); // Reset held for 16 cycles
    reset_i <= 1'b0;

    // A row whose first value never loaded marks the end of the table
    row = 0;
    while ((row < MAX_ROWS) && (table_mem[row*FIELDS] < (1 << TW)))
    begin
      @(posedge clk);
      drive_row(row);
      if (table_mem[row*FIELDS+17][0])
      begin
        flagged_rows++;
      end
      row++;
    end
    if (row == 0)
    begin
      $display("No stimulus rows could be read from verif/regread_testdata.txt");
      other_errors++;
    end
    if (row == MAX_ROWS)
    begin
      $display("Timeout: the stimulus table did not end within %0d rows", MAX_ROWS);
      other_errors++;
    end

    @(posedge clk);
    drive_idle();

    wait_cycles = 0; // The checker samples each flagged row half a cycle later
    while ((check_count < flagged_rows) && (wait_cycles < DRAIN_LIMIT))
    begin
      @(posedge clk);
      wait_cycles++;
    end
    if (check_count < flagged_rows)
    begin
      $display("Timeout: the checker saw %0d of %0d flagged cycles", check_count, flagged_rows);
      other_errors++;
    end

    assert_errors = dut.u_props.fail_count;
    u_checker.print_summary(assert_errors, other_errors);
    if ((error_count == 0) && (assert_errors == 0) && (other_errors == 0))
    begin
      $display("TEST PASSED");
    end
    else
    begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
